/* hw/mem_map_pkg.sv */
package mem_map_pkg;

    //////////////////////////////////////////////////
    // basic types
    //////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [7:0]  char_t;
    typedef logic [29:0] word_addr_t;

    // region code lives in word address bits 29..26
    typedef enum logic [3:0] {
        REGION_FLASH  = 4'hb,
        REGION_TEXT   = 4'hc,
        REGION_TRAP   = 4'hd,
        REGION_KBD    = 4'he,
        REGION_LOADER = 4'hf
    } region_e;

    //////////////////////////////////////////////////
    // sizes and timing
    //////////////////////////////////////////////////

    localparam logic [7:0] TRAP_TAG = 8'hdd;

    localparam int LOADER_AW = 13;
    localparam int TEXT_AW   = 15;

    // a text write holds the pipeline for TEXT_SPIN cycles
    localparam int TEXT_WAIT_CYCLES = 5;
    localparam int TEXT_SPIN        = TEXT_WAIT_CYCLES + 3;
    localparam int TEXT_CNT_W       = $clog2(TEXT_SPIN + 1);

    localparam int KBD_DEPTH = 8;
    localparam int KBD_PTR_W = $clog2(KBD_DEPTH);
    localparam int KBD_CNT_W = $clog2(KBD_DEPTH + 1);

    //////////////////////////////////////////////////
    // request bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        logic       read;
        logic       write;
        word_addr_t addr;
        word_t      wdata;
        logic [3:0] byte_en;
    } dmem_req_t;

    typedef struct packed {
        logic ic_read;
        logic dc_read;
        logic dc_write;
    } cache_req_t;

    typedef struct packed {
        logic [LOADER_AW-1:0] addr;
        word_t                wdata;
        logic [3:0]           wen;
    } loader_wr_t;

    typedef struct packed {
        logic               req;
        logic [TEXT_AW-1:0] addr;
        char_t              char;
    } text_wr_t;

    // frame receiver states
    typedef enum logic [1:0] {
        PS2_IDLE,
        PS2_DATA,
        PS2_PARITY,
        PS2_STOP
    } ps2_state_e;

endpackage

/* hw/mem_region_decoder.sv */
module mem_region_decoder import mem_map_pkg::*; (
    input  dmem_req_t  dmem,
    input  word_addr_t instr_addr,
    input  word_t      dc_data,
    input  word_t      ic_data,
    input  word_t      loader_data,
    input  word_t      loader_instr,
    input  char_t      kb_keycode,
    input  logic       kb_ready,
    output cache_req_t cache_req,
    output loader_wr_t loader_wr,
    output text_wr_t   text_wr,
    output logic       kb_pop,
    output logic       trap_stall,
    output logic       kb_stall,
    output word_t      dmem_data,
    output word_t      instr_data
);

    region_e data_region;
    region_e instr_region;

    assign data_region  = region_e'(dmem.addr[29:26]);
    assign instr_region = region_e'(instr_addr[29:26]);

    //////////////////////////////////////////////////
    // data side strobes and read mux
    //////////////////////////////////////////////////

    always_comb begin
        cache_req.dc_read  = 1'b0;
        cache_req.dc_write = 1'b0;
        loader_wr.wen      = 4'b0000;
        text_wr.req        = 1'b0;
        kb_pop             = 1'b0;
        trap_stall         = 1'b0;
        // flash, text, trap and debug reads land here
        dmem_data          = '0;

        case (data_region)
            REGION_FLASH: begin
                dmem_data = '0;
            end
            REGION_TEXT: begin
                text_wr.req = dmem.write;
            end
            REGION_TRAP: begin
                if (dmem.addr[25:18] == TRAP_TAG) begin
                    trap_stall = dmem.read | dmem.write;
                end
            end
            REGION_KBD: begin
                kb_pop    = dmem.read;
                dmem_data = {24'd0, kb_keycode};
            end
            REGION_LOADER: begin
                // byte lanes are mirrored in loader storage
                if (dmem.write) begin
                    case (dmem.byte_en)
                        4'b0001: loader_wr.wen = 4'b1000;
                        4'b0010: loader_wr.wen = 4'b0100;
                        4'b0100: loader_wr.wen = 4'b0010;
                        4'b1000: loader_wr.wen = 4'b0001;
                        default: loader_wr.wen = 4'b1111;
                    endcase
                end
                dmem_data = loader_data;
            end
            default: begin
                // main memory through the cache
                cache_req.dc_read  = dmem.read;
                cache_req.dc_write = dmem.write;
                dmem_data          = dc_data;
            end
        endcase
    end

    assign kb_stall = kb_pop & ~kb_ready;

    assign loader_wr.addr  = dmem.addr[LOADER_AW-1:0];
    assign loader_wr.wdata = dmem.wdata;

    //////////////////////////////////////////////////
    // text byte select
    //////////////////////////////////////////////////

    always_comb begin
        case (dmem.byte_en)
            4'b1000: begin
                text_wr.addr = {dmem.addr[TEXT_AW-3:0], 2'd0};
                text_wr.char = dmem.wdata[7:0];
            end
            4'b0100: begin
                text_wr.addr = {dmem.addr[TEXT_AW-3:0], 2'd1};
                text_wr.char = dmem.wdata[15:8];
            end
            4'b0010: begin
                text_wr.addr = {dmem.addr[TEXT_AW-3:0], 2'd2};
                text_wr.char = dmem.wdata[23:16];
            end
            default: begin
                // 0001 and every wider enable use lane 3
                text_wr.addr = {dmem.addr[TEXT_AW-3:0], 2'd3};
                text_wr.char = dmem.wdata[31:24];
            end
        endcase
    end

    // instruction fetch from loader region bypasses the cache
    assign cache_req.ic_read = (instr_region != REGION_LOADER);
    assign instr_data = (instr_region == REGION_LOADER) ? loader_instr : ic_data;

    // at most one data target is strobed per access
    a_one_target: assert final (
        $onehot0({cache_req.dc_read, kb_pop, |loader_wr.wen})
    ) else $error("more than one data target strobed");

endmodule

/* hw/loader_ram.sv */
module loader_ram import mem_map_pkg::*; (
    input  logic                 clk_pipeline,
    input  loader_wr_t           wr,
    input  logic [LOADER_AW-1:0] instr_addr,
    output word_t                data,
    output word_t                instr
);

    word_t mem [2**LOADER_AW];

    //////////////////////////////////////////////////
    // data port, read before write
    //////////////////////////////////////////////////

    always_ff @(posedge clk_pipeline) begin
        for (int i = 0; i < 4; i++) begin
            if (wr.wen[i]) begin
                mem[wr.addr][8*i +: 8] <= wr.wdata[8*i +: 8];
            end
        end
        data <= mem[wr.addr];
    end

    // instruction port, read only
    always_ff @(posedge clk_pipeline) begin
        instr <= mem[instr_addr];
    end

endmodule

/* hw/text_mem_writer.sv */
module text_mem_writer import mem_map_pkg::*; (
    input  logic               clk_pipeline,
    input  logic               rst,
    input  text_wr_t           wr,
    input  logic [TEXT_AW-1:0] rd_addr,
    output logic               stall,
    output char_t              rd_char
);

    logic [TEXT_CNT_W-1:0] stall_cnt;
    logic                  wr_en;

    char_t text_mem [2**TEXT_AW];

    //////////////////////////////////////////////////
    // write timing
    //////////////////////////////////////////////////

    // counter idles at 0 and spins at TEXT_SPIN until req drops
    always_ff @(posedge clk_pipeline) begin
        if (!rst || !wr.req) begin
            stall_cnt <= '0;
            wr_en     <= 1'b0;
        end else begin
            if (stall_cnt != TEXT_CNT_W'(TEXT_SPIN)) begin
                stall_cnt <= stall_cnt + 1'b1;
            end
            wr_en <= (stall_cnt <= TEXT_CNT_W'(TEXT_WAIT_CYCLES));
        end
    end

    // release the pipeline once the spin value is reached
    assign stall = wr.req && (stall_cnt <= TEXT_CNT_W'(TEXT_SPIN - 1));

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk_pipeline) begin
        if (wr_en) begin
            text_mem[wr.addr] <= wr.char;
        end
    end

    // display side read
    always_ff @(posedge clk_pipeline) begin
        rd_char <= text_mem[rd_addr];
    end

    a_wen_after_req: assert property (
        @(posedge clk_pipeline) disable iff (!rst)
        wr_en |-> $past(wr.req)
    ) else $error("text write enable without a request");

    a_cnt_bound: assert property (
        @(posedge clk_pipeline) disable iff (!rst)
        stall_cnt <= TEXT_CNT_W'(TEXT_SPIN)
    ) else $error("text stall counter past spin value");

endmodule

/* hw/ps2_keyboard.sv */
module ps2_keyboard import mem_map_pkg::*; (
    input  logic  clk_pipeline,
    input  logic  rst,
    input  logic  ps2_clk,
    input  logic  ps2_data,
    input  logic  pop,
    output logic  ready,
    output logic  overflow,
    output char_t keycode
);

    logic [2:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_fall;
    logic       data_bit;

    ps2_state_e state;
    logic [2:0] bit_cnt;
    char_t      shift_reg;
    logic       parity_ok;
    logic       push;

    char_t                queue [KBD_DEPTH];
    logic [KBD_PTR_W-1:0] head;
    logic [KBD_PTR_W-1:0] tail;
    logic [KBD_CNT_W-1:0] count;
    logic                 push_en;
    logic                 pop_en;

    //////////////////////////////////////////////////
    // input sync and edge detect
    //////////////////////////////////////////////////

    // two sync stages plus one for the edge
    always_ff @(posedge clk_pipeline) begin
        clk_sync  <= {clk_sync[1:0], ps2_clk};
        data_sync <= {data_sync[0], ps2_data};
    end

    assign clk_fall = clk_sync[2] & ~clk_sync[1];
    assign data_bit = data_sync[1];

    //////////////////////////////////////////////////
    // frame receiver
    //////////////////////////////////////////////////

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            state   <= PS2_IDLE;
            bit_cnt <= '0;
        end else if (clk_fall) begin
            case (state)
                PS2_IDLE: begin
                    // wait for a start bit of 0
                    if (!data_bit) begin
                        state   <= PS2_DATA;
                        bit_cnt <= '0;
                    end
                end
                PS2_DATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        state <= PS2_PARITY;
                    end
                end
                PS2_PARITY: state <= PS2_STOP;
                default:    state <= PS2_IDLE;
            endcase
        end
    end

    // payload, LSB first
    always_ff @(posedge clk_pipeline) begin
        if (clk_fall && state == PS2_DATA) begin
            shift_reg <= {data_bit, shift_reg[7:1]};
        end
        if (clk_fall && state == PS2_PARITY) begin
            // odd parity over data and parity bit
            parity_ok <= ^{shift_reg, data_bit};
        end
    end

    // good stop bit and parity push the scancode
    assign push = clk_fall && (state == PS2_STOP) && data_bit && parity_ok;

    //////////////////////////////////////////////////
    // scancode queue
    //////////////////////////////////////////////////

    assign ready   = (count != '0);
    assign pop_en  = pop && ready;
    assign push_en = push && (count != KBD_CNT_W'(KBD_DEPTH));
    assign keycode = queue[head];

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push && !push_en) begin
                overflow <= 1'b1;
            end
            if (push_en) begin
                tail <= tail + 1'b1;
            end
            if (pop_en) begin
                head <= head + 1'b1;
            end
            count <= count + KBD_CNT_W'(push_en) - KBD_CNT_W'(pop_en);
        end
    end

    always_ff @(posedge clk_pipeline) begin
        if (push_en) begin
            queue[tail] <= shift_reg;
        end
    end

    a_count_bound: assert property (
        @(posedge clk_pipeline) disable iff (!rst)
        count <= KBD_CNT_W'(KBD_DEPTH)
    ) else $error("scancode queue count past depth");

endmodule

/* hw/cpu_interface.sv */
module cpu_interface import mem_map_pkg::*; (
    input  logic               clk_pipeline,
    input  logic               rst,

    // cpu side
    input  dmem_req_t          dmem,
    input  word_addr_t         instr_addr,
    output word_t              instr_data,
    output word_t              dmem_data,
    output logic               mem_stall,
    output logic               trap_stall,

    // external cache port
    input  word_t              ic_data,
    input  word_t              dc_data,
    input  logic               cache_stall,
    output cache_req_t         cache_req,

    // keyboard
    input  logic               ps2_clk,
    input  logic               ps2_data,
    output logic               kb_ready,
    output logic               kb_overflow,

    // display read port
    input  logic [TEXT_AW-1:0] text_rd_addr,
    output char_t              text_rd_char
);

    loader_wr_t loader_wr;
    word_t      loader_data;
    word_t      loader_instr;
    text_wr_t   text_wr;
    logic       text_stall;
    logic       kb_pop;
    logic       kb_stall;
    char_t      kb_keycode;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    mem_region_decoder i_mem_region_decoder (
        .dmem         (dmem),
        .instr_addr   (instr_addr),
        .dc_data      (dc_data),
        .ic_data      (ic_data),
        .loader_data  (loader_data),
        .loader_instr (loader_instr),
        .kb_keycode   (kb_keycode),
        .kb_ready     (kb_ready),
        .cache_req    (cache_req),
        .loader_wr    (loader_wr),
        .text_wr      (text_wr),
        .kb_pop       (kb_pop),
        .trap_stall   (trap_stall),
        .kb_stall     (kb_stall),
        .dmem_data    (dmem_data),
        .instr_data   (instr_data)
    );

    //////////////////////////////////////////////////
    // targets
    //////////////////////////////////////////////////

    // instruction port sees only the low word address bits
    loader_ram i_loader_ram (
        .clk_pipeline (clk_pipeline),
        .wr           (loader_wr),
        .instr_addr   (instr_addr[LOADER_AW-1:0]),
        .data         (loader_data),
        .instr        (loader_instr)
    );

    text_mem_writer i_text_mem_writer (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .wr           (text_wr),
        .rd_addr      (text_rd_addr),
        .stall        (text_stall),
        .rd_char      (text_rd_char)
    );

    ps2_keyboard i_ps2_keyboard (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .pop          (kb_pop),
        .ready        (kb_ready),
        .overflow     (kb_overflow),
        .keycode      (kb_keycode)
    );

    // any source holds the whole pipeline
    assign mem_stall = cache_stall | text_stall | kb_stall | trap_stall;

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk_pipeline,
    output logic rst
);

    // period of 20
    initial begin
        clk_pipeline = 1'b0;
        forever #10 clk_pipeline = ~clk_pipeline;
    end

    // reset held low for eight rising edges, released mid cycle
    initial begin
        rst = 1'b0;
        repeat (8) @(posedge clk_pipeline);
        @(negedge clk_pipeline);
        rst = 1'b1;
    end

endmodule

/* test/cpu_interface_tb.sv */
module cpu_interface_tb import mem_map_pkg::*; ();

    localparam int PS2_HALF     = 4;
    localparam int MAIN_N       = 40;
    localparam int LOADER_N     = 24;
    localparam int TEXT_N       = 6;
    localparam int FRAME_N      = 14;
    localparam int FRAME_CYCLES = 11 * PS2_HALF * 2;
    localparam int CYCLE_LIMIT  = 10 + MAIN_N + 4 * LOADER_N + TEXT_N * (TEXT_SPIN + 5)
                                + FRAME_N * (FRAME_CYCLES + 3) + 4 * FRAME_N + 60 + 200;

    logic               clk_pipeline;
    logic               rst;
    dmem_req_t          dmem;
    word_addr_t         instr_addr;
    word_t              instr_data;
    word_t              dmem_data;
    logic               mem_stall;
    logic               trap_stall;
    word_t              ic_data;
    word_t              dc_data;
    logic               cache_stall;
    cache_req_t         cache_req;
    logic               ps2_clk;
    logic               ps2_data;
    logic               kb_ready;
    logic               kb_overflow;
    logic [TEXT_AW-1:0] text_rd_addr;
    char_t              text_rd_char;

    // reference model state
    word_t  loader_model [2**LOADER_AW];
    char_t  text_model [2**TEXT_AW];
    char_t  kbd_model [$];
    logic   overflow_model;
    integer seed;
    int     error_count;
    int     cycle_count = 0;

    tb_clock_gen i_tb_clock_gen (
        .clk_pipeline (clk_pipeline),
        .rst          (rst)
    );

    cpu_interface i_cpu_interface (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .dmem         (dmem),
        .instr_addr   (instr_addr),
        .instr_data   (instr_data),
        .dmem_data    (dmem_data),
        .mem_stall    (mem_stall),
        .trap_stall   (trap_stall),
        .ic_data      (ic_data),
        .dc_data      (dc_data),
        .cache_stall  (cache_stall),
        .cache_req    (cache_req),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .kb_ready     (kb_ready),
        .kb_overflow  (kb_overflow),
        .text_rd_addr (text_rd_addr),
        .text_rd_char (text_rd_char)
    );

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "word mismatch on %s", name);
        end
    endtask

    task automatic check_char(input string name, input char_t expected, input char_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "char mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "bit mismatch on %s", name);
        end
    endtask

    // run limit
    always @(posedge clk_pipeline) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////
    // model rules and drivers
    //////////////////////////////////////////////////

    // loader storage keeps bytes in mirrored lanes
    function automatic logic [3:0] loader_lanes(input logic [3:0] byte_en);
        case (byte_en)
            4'b0001: return 4'b1000;
            4'b0010: return 4'b0100;
            4'b0100: return 4'b0010;
            4'b1000: return 4'b0001;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [1:0] text_lane(input logic [3:0] byte_en);
        case (byte_en)
            4'b1000: return 2'd0;
            4'b0100: return 2'd1;
            4'b0010: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    task automatic idle_inputs();
        dmem        = '0;
        instr_addr  = '0;
        ic_data     = '0;
        dc_data     = '0;
        cache_stall = 1'b0;
    endtask

    // start, data LSB first, odd parity, stop
    task automatic send_frame(input char_t code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int b = 0; b < 11; b++) begin
            @(negedge clk_pipeline);
            ps2_data = bits[b];
            repeat (PS2_HALF - 1) @(negedge clk_pipeline);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge clk_pipeline);
            ps2_clk = 1'b1;
        end
        if (!bad_parity) begin
            if (kbd_model.size() < KBD_DEPTH) begin
                kbd_model.push_back(code);
            end else begin
                overflow_model = 1'b1;
            end
        end
        repeat (2) @(negedge clk_pipeline);
    endtask

    task automatic pop_and_check();
        char_t head;
        @(negedge clk_pipeline);
        idle_inputs();
        dmem.read = 1'b1;
        dmem.addr = {REGION_KBD, 26'($random(seed))};
        #5;
        head = kbd_model.pop_front();
        check_bit("kb_ready", 1'b1, kb_ready);
        check_word("dmem_data", {24'd0, head}, dmem_data);
        check_bit("mem_stall", 1'b0, mem_stall);
        @(negedge clk_pipeline);
        idle_inputs();
        #5;
        check_bit("kb_ready", kbd_model.size() != 0, kb_ready);
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic main_memory_test();
        logic [3:0] region;
        logic       in_loader;
        for (int n = 0; n < MAIN_N; n++) begin
            @(negedge clk_pipeline);
            region       = 4'($unsigned($random(seed)) % 11);
            in_loader    = 1'($random(seed));
            dmem.read    = 1'($random(seed));
            dmem.write   = 1'($random(seed));
            dmem.addr    = {region, 26'($random(seed))};
            dmem.wdata   = $random(seed);
            dmem.byte_en = 4'($random(seed));
            dc_data      = $random(seed);
            ic_data      = $random(seed);
            cache_stall  = 1'($random(seed));
            if (in_loader) begin
                instr_addr = {REGION_LOADER, 26'($random(seed))};
            end else begin
                instr_addr = {region, 26'($random(seed))};
            end
            #5;
            check_bit("cache_req.dc_read", dmem.read, cache_req.dc_read);
            check_bit("cache_req.dc_write", dmem.write, cache_req.dc_write);
            check_bit("cache_req.ic_read", !in_loader, cache_req.ic_read);
            check_word("dmem_data", dc_data, dmem_data);
            check_bit("mem_stall", cache_stall, mem_stall);
            if (!in_loader) begin
                check_word("instr_data", ic_data, instr_data);
            end
        end
    endtask

    task automatic loader_test();
        logic [LOADER_AW-1:0] la;
        logic [3:0]           wen;
        for (int n = 0; n < LOADER_N; n++) begin
            la = LOADER_AW'($random(seed));
            // whole word first, so no byte is left unknown
            @(negedge clk_pipeline);
            idle_inputs();
            dmem.write   = 1'b1;
            dmem.addr    = {REGION_LOADER, 13'($random(seed)), la};
            dmem.byte_en = 4'b1111;
            dmem.wdata   = $random(seed);
            loader_model[la] = dmem.wdata;
            #5;
            check_bit("cache_req.dc_write", 1'b0, cache_req.dc_write);
            @(negedge clk_pipeline);
            dmem.byte_en = 4'($random(seed));
            dmem.wdata   = $random(seed);
            wen = loader_lanes(dmem.byte_en);
            for (int i = 0; i < 4; i++) begin
                if (wen[i]) begin
                    loader_model[la][8*i +: 8] = dmem.wdata[8*i +: 8];
                end
            end
            // read back through both ports
            @(negedge clk_pipeline);
            dmem.write = 1'b0;
            dmem.read  = 1'b1;
            instr_addr = {REGION_LOADER, 13'($random(seed)), la};
            @(negedge clk_pipeline);
            #5;
            check_word("dmem_data", loader_model[la], dmem_data);
            check_word("instr_data", loader_model[la], instr_data);
            check_bit("cache_req.ic_read", 1'b0, cache_req.ic_read);
        end
    endtask

    task automatic text_test();
        logic [1:0]         lane;
        logic [TEXT_AW-1:0] written [TEXT_N];
        for (int n = 0; n < TEXT_N; n++) begin
            @(negedge clk_pipeline);
            idle_inputs();
            dmem.write   = 1'b1;
            dmem.addr    = {REGION_TEXT, 26'($random(seed))};
            dmem.wdata   = $random(seed);
            dmem.byte_en = 4'($random(seed));
            lane = text_lane(dmem.byte_en);
            written[n] = {dmem.addr[TEXT_AW-3:0], lane};
            text_model[written[n]] = dmem.wdata[8*lane +: 8];
            // stall spans TEXT_SPIN cycles from the first one
            for (int c = 0; c < TEXT_SPIN; c++) begin
                if (c > 0) begin
                    @(negedge clk_pipeline);
                end
                #5;
                check_bit("mem_stall", 1'b1, mem_stall);
            end
            @(negedge clk_pipeline);
            #5;
            check_bit("mem_stall", 1'b0, mem_stall);
            @(negedge clk_pipeline);
            idle_inputs();
        end
        for (int n = 0; n < TEXT_N; n++) begin
            @(negedge clk_pipeline);
            text_rd_addr = written[n];
            @(negedge clk_pipeline);
            #5;
            check_char("text_rd_char", text_model[written[n]], text_rd_char);
        end
    endtask

    task automatic keyboard_test();
        // third frame carries a bad parity bit
        for (int n = 0; n < 5; n++) begin
            send_frame(8'($random(seed)), n == 2);
            #5;
            check_bit("kb_ready", kbd_model.size() != 0, kb_ready);
            check_bit("kb_overflow", overflow_model, kb_overflow);
        end
        while (kbd_model.size() != 0) begin
            pop_and_check();
        end
        // empty queue read
        @(negedge clk_pipeline);
        dmem.read = 1'b1;
        dmem.addr = {REGION_KBD, 26'($random(seed))};
        repeat (3) begin
            #5;
            check_bit("mem_stall", 1'b1, mem_stall);
            @(negedge clk_pipeline);
        end
        idle_inputs();
        for (int n = 0; n < KBD_DEPTH + 1; n++) begin
            send_frame(8'($random(seed)), 1'b0);
        end
        #5;
        check_bit("kb_overflow", overflow_model, kb_overflow);
        check_bit("kb_ready", 1'b1, kb_ready);
        while (kbd_model.size() != 0) begin
            pop_and_check();
        end
        check_bit("kb_overflow", 1'b1, kb_overflow);
    endtask

    task automatic trap_test();
        int         hold;
        logic       is_read;
        logic [7:0] tag;
        @(negedge clk_pipeline);
        idle_inputs();
        is_read    = 1'($random(seed));
        dmem.read  = is_read;
        dmem.write = !is_read;
        dmem.addr  = {REGION_TRAP, TRAP_TAG, 18'($random(seed))};
        hold = 2 + int'($unsigned($random(seed)) % 5);
        for (int c = 0; c < hold; c++) begin
            #5;
            check_bit("trap_stall", 1'b1, trap_stall);
            check_bit("mem_stall", 1'b1, mem_stall);
            @(negedge clk_pipeline);
        end
        idle_inputs();
        #5;
        check_bit("trap_stall", 1'b0, trap_stall);
        check_bit("mem_stall", 1'b0, mem_stall);
        // flash, text and untagged trap reads give zero
        for (int n = 0; n < 12; n++) begin
            @(negedge clk_pipeline);
            idle_inputs();
            dmem.read = 1'b1;
            dc_data   = $random(seed);
            tag       = 8'($random(seed));
            if (tag == TRAP_TAG) begin
                tag = 8'h00;
            end
            case (n % 3)
                0:       dmem.addr = {REGION_FLASH, 26'($random(seed))};
                1:       dmem.addr = {REGION_TEXT, 26'($random(seed))};
                default: dmem.addr = {REGION_TRAP, tag, 18'($random(seed))};
            endcase
            #5;
            check_word("dmem_data", 32'd0, dmem_data);
            check_bit("trap_stall", 1'b0, trap_stall);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        seed           = 32'h3dee_7e13;
        error_count    = 0;
        overflow_model = 1'b0;
        idle_inputs();
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;
        text_rd_addr = '0;
        wait (rst === 1'b1);
        @(negedge clk_pipeline);
        #5;
        check_bit("mem_stall", 1'b0, mem_stall);
        check_bit("kb_ready", 1'b0, kb_ready);
        check_bit("kb_overflow", 1'b0, kb_overflow);
        main_memory_test();
        loader_test();
        text_test();
        keyboard_test();
        trap_test();
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
hw/mem_map_pkg.sv
hw/mem_region_decoder.sv
hw/loader_ram.sv
hw/text_mem_writer.sv
hw/ps2_keyboard.sv
hw/cpu_interface.sv
test/tb_clock_gen.sv
test/cpu_interface_tb.sv
